/* common/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// main array geometry
`define DCACHE_SETS 8
`define DCACHE_INDEX_BITS 3
`define DCACHE_TAG_BITS 13

// word address and one-word line
`define DCACHE_ADDR_BITS 16
`define DCACHE_WORD_BITS 32

// fully associative victim store
`define DCACHE_VICTIM_ENTRIES 2

`define DCACHE_CNT_BITS 16

`endif

/* common/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    // word address, split as {tag, index}
    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

    // one line is one word
    typedef logic [`DCACHE_WORD_BITS-1:0] word_t;

    typedef logic [`DCACHE_CNT_BITS-1:0] cnt_t;

    // way of a set, or entry of the victim store
    typedef logic way_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        SWAP,
        WRITE_BACK,
        MOVE_TO_VICTIM,
        FILL
    } dcache_state_t;

endpackage

/* common/dcache_ctrl_if.sv */
`timescale 1ns/1ps

interface dcache_ctrl_if;
    import dcache_pkg::*;

    // main array status
    logic main_hit;
    way_t hit_way;
    way_t lru_way;
    logic lru_valid;
    logic lru_dirty;
    addr_t evict_addr;
    word_t evict_data;

    // victim store status and returning line
    logic victim_hit;
    logic victim_lru_valid;
    logic victim_lru_dirty;
    word_t victim_data;
    logic victim_dirty;

    // strobes from the controller
    logic ld_lru;
    logic cpu_write_hit;
    logic swap;
    logic insert_victim;
    logic fill;

    modport ctrl (
        input main_hit, lru_valid, victim_hit, victim_lru_valid, victim_lru_dirty,
        output ld_lru, cpu_write_hit, swap, insert_victim, fill
    );

    modport dpath (
        output main_hit, hit_way, lru_way, lru_valid, lru_dirty, evict_addr, evict_data,
        input ld_lru, cpu_write_hit, swap, fill, victim_data, victim_dirty
    );

    modport victim (
        output victim_hit, victim_lru_valid, victim_lru_dirty, victim_data, victim_dirty,
        input swap, insert_victim, lru_valid, lru_dirty, evict_addr, evict_data
    );

endinterface

/* dcache/dcache_control.sv */
`timescale 1ns/1ps

module dcache_control (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    input logic pmem_resp,
    dcache_ctrl_if.ctrl ctrl,
    output dcache_pkg::cnt_t miss_count,
    output dcache_pkg::cnt_t victim_hit_count,
    output dcache_pkg::cnt_t writeback_count
);
    import dcache_pkg::*;

    dcache_state_t state;
    dcache_state_t next_state;

    logic miss_start;
    logic wb_done;

    // state register
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // first cycle of a full miss, and a write-back accepted by memory
    assign miss_start = (state == CHECK) && !ctrl.main_hit && !ctrl.victim_hit;
    assign wb_done = (state == WRITE_BACK) && pmem_resp;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            miss_count <= '0;
            victim_hit_count <= '0;
            writeback_count <= '0;
        end
        else
        begin
            if (miss_start)
                miss_count <= miss_count + 1'b1;
            if (state == SWAP)
                victim_hit_count <= victim_hit_count + 1'b1;
            if (wb_done)
                writeback_count <= writeback_count + 1'b1;
        end
    end

    // next state
    always_comb
    begin
        next_state = state;
        unique case (state)
            IDLE:
            begin
                if (mem_read || mem_write)
                    next_state = CHECK;
            end
            CHECK:
            begin
                if (ctrl.main_hit)
                    next_state = IDLE;
                else if (ctrl.victim_hit)
                    next_state = SWAP;
                else if (!ctrl.lru_valid)
                    next_state = FILL;
                else if (ctrl.victim_lru_valid && ctrl.victim_lru_dirty)
                    next_state = WRITE_BACK;
                else
                    next_state = MOVE_TO_VICTIM;
            end
            SWAP:
                next_state = CHECK;
            WRITE_BACK:
            begin
                if (pmem_resp)
                    next_state = MOVE_TO_VICTIM;
            end
            MOVE_TO_VICTIM:
                next_state = FILL;
            FILL:
            begin
                if (pmem_resp)
                    next_state = CHECK;
            end
            default:
                next_state = IDLE;
        endcase
    end

    // outputs
    always_comb
    begin
        set_defaults();
        unique case (state)
            CHECK:
            begin
                mem_resp = ctrl.main_hit;
                ctrl.ld_lru = ctrl.main_hit;
                ctrl.cpu_write_hit = ctrl.main_hit && mem_write;
            end
            SWAP:
                ctrl.swap = 1'b1;
            WRITE_BACK:
                pmem_write = 1'b1;
            MOVE_TO_VICTIM:
                ctrl.insert_victim = 1'b1;
            FILL:
            begin
                pmem_read = 1'b1;
                // line is written on the edge that ends the read
                ctrl.fill = pmem_resp;
            end
            default:;
        endcase
    end

    function void set_defaults();
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        ctrl.ld_lru = 1'b0;
        ctrl.cpu_write_hit = 1'b0;
        ctrl.swap = 1'b0;
        ctrl.insert_victim = 1'b0;
        ctrl.fill = 1'b0;
    endfunction

endmodule : dcache_control

/* dcache/dcache_datapath.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_datapath (
    input logic clk,
    input logic rst,
    input dcache_pkg::addr_t mem_addr,
    input dcache_pkg::word_t mem_wdata,
    output dcache_pkg::word_t mem_rdata,
    input dcache_pkg::word_t pmem_rdata,
    output dcache_pkg::addr_t fill_addr,
    dcache_ctrl_if.dpath dp
);
    import dcache_pkg::*;

    localparam int WAYS = 2;

    tag_t tag_arr [`DCACHE_SETS][WAYS];
    word_t data_arr [`DCACHE_SETS][WAYS];
    logic valid_arr [`DCACHE_SETS][WAYS];
    logic dirty_arr [`DCACHE_SETS][WAYS];
    // per set, the way to replace next
    way_t lru_arr [`DCACHE_SETS];

    index_t idx;
    tag_t tag;

    logic line_ld;
    word_t line_data;
    logic line_dirty;

    assign idx = mem_addr[`DCACHE_INDEX_BITS-1:0];
    assign tag = mem_addr[`DCACHE_ADDR_BITS-1:`DCACHE_INDEX_BITS];

    // tag compare across both ways
    always_comb
    begin
        dp.main_hit = 1'b0;
        dp.hit_way = 1'b0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (valid_arr[idx][w] && (tag_arr[idx][w] == tag))
            begin
                dp.main_hit = 1'b1;
                dp.hit_way = way_t'(w);
            end
        end
    end

    assign mem_rdata = data_arr[idx][dp.hit_way];
    assign fill_addr = {tag, idx};

    // eviction candidate
    assign dp.lru_way = lru_arr[idx];
    assign dp.lru_valid = valid_arr[idx][dp.lru_way];
    assign dp.lru_dirty = dirty_arr[idx][dp.lru_way];
    assign dp.evict_addr = {tag_arr[idx][dp.lru_way], idx};
    assign dp.evict_data = data_arr[idx][dp.lru_way];

    // incoming line comes from memory or from the victim store
    assign line_ld = dp.fill || dp.swap;
    assign line_data = dp.swap ? dp.victim_data : pmem_rdata;
    assign line_dirty = dp.swap && dp.victim_dirty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `DCACHE_SETS; s++)
            begin
                lru_arr[s] <= 1'b0;
                for (int w = 0; w < WAYS; w++)
                begin
                    valid_arr[s][w] <= 1'b0;
                    dirty_arr[s][w] <= 1'b0;
                end
            end
        end
        else
        begin
            if (line_ld)
            begin
                valid_arr[idx][dp.lru_way] <= 1'b1;
                dirty_arr[idx][dp.lru_way] <= line_dirty;
                lru_arr[idx] <= ~dp.lru_way;
            end
            else if (dp.cpu_write_hit)
                dirty_arr[idx][dp.hit_way] <= 1'b1;
            if (dp.ld_lru)
                lru_arr[idx] <= ~dp.hit_way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line_ld)
        begin
            tag_arr[idx][dp.lru_way] <= tag;
            data_arr[idx][dp.lru_way] <= line_data;
        end
        else if (dp.cpu_write_hit)
            data_arr[idx][dp.hit_way] <= mem_wdata;
    end

endmodule : dcache_datapath

/* dcache/victim_cache.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module victim_cache (
    input logic clk,
    input logic rst,
    input dcache_pkg::addr_t mem_addr,
    output dcache_pkg::addr_t wb_addr,
    output dcache_pkg::word_t wb_data,
    dcache_ctrl_if.victim vc
);
    import dcache_pkg::*;

    addr_t v_addr [`DCACHE_VICTIM_ENTRIES];
    word_t v_data [`DCACHE_VICTIM_ENTRIES];
    logic v_valid [`DCACHE_VICTIM_ENTRIES];
    logic v_dirty [`DCACHE_VICTIM_ENTRIES];
    way_t v_lru;

    way_t hit_entry;
    way_t wr_entry;

    // full address compare
    always_comb
    begin
        vc.victim_hit = 1'b0;
        hit_entry = 1'b0;
        for (int e = 0; e < `DCACHE_VICTIM_ENTRIES; e++)
        begin
            if (v_valid[e] && (v_addr[e] == mem_addr))
            begin
                vc.victim_hit = 1'b1;
                hit_entry = way_t'(e);
            end
        end
    end

    assign vc.victim_data = v_data[hit_entry];
    assign vc.victim_dirty = v_dirty[hit_entry];

    // lru entry is the next one to leave
    assign vc.victim_lru_valid = v_valid[v_lru];
    assign vc.victim_lru_dirty = v_dirty[v_lru];
    assign wb_addr = v_addr[v_lru];
    assign wb_data = v_data[v_lru];

    assign wr_entry = vc.swap ? hit_entry : v_lru;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            v_lru <= 1'b0;
            for (int e = 0; e < `DCACHE_VICTIM_ENTRIES; e++)
            begin
                v_valid[e] <= 1'b0;
                v_dirty[e] <= 1'b0;
            end
        end
        else if (vc.swap || vc.insert_victim)
        begin
            v_valid[wr_entry] <= vc.lru_valid;
            v_dirty[wr_entry] <= vc.lru_dirty;
            v_lru <= ~wr_entry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (vc.swap || vc.insert_victim)
        begin
            v_addr[wr_entry] <= vc.evict_addr;
            v_data[wr_entry] <= vc.evict_data;
        end
    end

endmodule : victim_cache

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input dcache_pkg::addr_t mem_addr,
    input dcache_pkg::word_t mem_wdata,
    output dcache_pkg::word_t mem_rdata,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output dcache_pkg::addr_t pmem_addr,
    output dcache_pkg::word_t pmem_wdata,
    input dcache_pkg::word_t pmem_rdata,
    input logic pmem_resp,
    output dcache_pkg::cnt_t miss_count,
    output dcache_pkg::cnt_t victim_hit_count,
    output dcache_pkg::cnt_t writeback_count
);
    import dcache_pkg::*;

    addr_t fill_addr;
    addr_t wb_addr;

    dcache_ctrl_if ctrl_bus ();

    dcache_control control (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .pmem_resp(pmem_resp),
        .ctrl(ctrl_bus.ctrl),
        .miss_count(miss_count),
        .victim_hit_count(victim_hit_count),
        .writeback_count(writeback_count)
    );

    dcache_datapath datapath (
        .clk(clk),
        .rst(rst),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .pmem_rdata(pmem_rdata),
        .fill_addr(fill_addr),
        .dp(ctrl_bus.dpath)
    );

    victim_cache victim (
        .clk(clk),
        .rst(rst),
        .mem_addr(mem_addr),
        .wb_addr(wb_addr),
        .wb_data(pmem_wdata),
        .vc(ctrl_bus.victim)
    );

    // write-backs leave from the victim store, fills use the request address
    assign pmem_addr = pmem_write ? wb_addr : fill_addr;

endmodule : dcache_top

/* testbench/dcache_sva.sv */
`timescale 1ns/1ps

module dcache_sva (
    input logic clk,
    input logic rst,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    // cpu response is a single-cycle pulse
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp)
        else $error("mem_resp held for more than one cycle");

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    // requests hold until memory answers
    read_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> pmem_read)
        else $error("pmem_read dropped before pmem_resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_write && !pmem_resp) |=> pmem_write)
        else $error("pmem_write dropped before pmem_resp");

endmodule : dcache_sva

bind dcache_control dcache_sva sva (
    .clk(clk),
    .rst(rst),
    .mem_resp(mem_resp),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .pmem_resp(pmem_resp)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int mem_words = 65536;
    localparam int timeout_cycles = 200;
    localparam int expected_writebacks = 5;

    typedef enum {main_hit, victim_hit, full_miss} access_class_t;

    typedef struct {
        logic wr;
        addr_t addr;
        word_t data;
        access_class_t cls;
    } access_t;

    logic clk;
    logic rst;
    logic mem_read;
    logic mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic mem_resp;
    logic pmem_read;
    logic pmem_write;
    addr_t pmem_addr;
    word_t pmem_wdata;
    word_t pmem_rdata;
    logic pmem_resp;
    cnt_t miss_count;
    cnt_t victim_hit_count;
    cnt_t writeback_count;

    word_t mem_model [mem_words];
    word_t shadow [mem_words];
    access_t accesses [$];
    int errors;
    int mem_writes;
    integer seed = 32'h719c_b5ce;

    // lines that leave the cache dirty during the run
    addr_t wb_lines [5] = '{16'h0105, 16'h0205, 16'h0405, 16'h0505, 16'h0605};

    dcache_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    function automatic word_t fill_pattern(input addr_t a);
        return {a ^ 16'h5ac3, ~a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic add_access(input logic wr, input addr_t addr, input word_t data,
                              input access_class_t cls);
        access_t acc;
        acc.wr = wr;
        acc.addr = addr;
        acc.data = data;
        acc.cls = cls;
        accesses.push_back(acc);
    endtask

    task automatic build_table();
        // empty sets
        add_access(1'b0, 16'h0010, 32'h0, full_miss);
        add_access(1'b0, 16'h0021, 32'h0, full_miss);
        add_access(1'b0, 16'h0032, 32'h0, full_miss);
        add_access(1'b1, 16'h0010, 32'h1111_0010, main_hit);
        add_access(1'b0, 16'h0010, 32'h0, main_hit);
        add_access(1'b1, 16'h0021, 32'h2222_0021, main_hit);
        add_access(1'b0, 16'h0021, 32'h0, main_hit);
        // three lines on set 3 push the first one into the victim store
        add_access(1'b0, 16'h0103, 32'h0, full_miss);
        add_access(1'b0, 16'h0203, 32'h0, full_miss);
        add_access(1'b0, 16'h0303, 32'h0, full_miss);
        add_access(1'b0, 16'h0103, 32'h0, victim_hit);
        // dirty lines overflow set 5
        add_access(1'b1, 16'h0105, 32'hd100_0105, full_miss);
        add_access(1'b1, 16'h0205, 32'hd200_0205, full_miss);
        add_access(1'b1, 16'h0305, 32'hd300_0305, full_miss);
        add_access(1'b1, 16'h0405, 32'hd400_0405, full_miss);
        add_access(1'b1, 16'h0505, 32'hd500_0505, full_miss);
        add_access(1'b1, 16'h0605, 32'hd600_0605, full_miss);
        add_access(1'b0, 16'h0305, 32'h0, victim_hit);
        // sweep over every written address
        add_access(1'b0, 16'h0010, 32'h0, main_hit);
        add_access(1'b0, 16'h0021, 32'h0, main_hit);
        add_access(1'b0, 16'h0105, 32'h0, full_miss);
        add_access(1'b0, 16'h0205, 32'h0, full_miss);
        add_access(1'b0, 16'h0305, 32'h0, victim_hit);
        add_access(1'b0, 16'h0405, 32'h0, full_miss);
        add_access(1'b0, 16'h0505, 32'h0, full_miss);
        add_access(1'b0, 16'h0605, 32'h0, full_miss);
        add_access(1'b0, 16'h0103, 32'h0, main_hit);
    endtask

    task automatic wait_resp(output int cycles, output logic seen);
        cycles = 0;
        seen = 1'b0;
        while (cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
            if (mem_resp)
            begin
                seen = 1'b1;
                break;
            end
        end
    endtask

    // memory answers after 1 to 4 cycles
    initial
    begin
        int delay;
        word_t rdata;
        pmem_resp <= 1'b0;
        pmem_rdata <= '0;
        forever
        begin
            @(negedge clk);
            if (pmem_read || pmem_write)
            begin
                delay = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
                repeat (delay - 1)
                    @(negedge clk);
                // address and data are held until the response
                if (pmem_write)
                begin
                    check_value("pmem_wdata", pmem_wdata, shadow[pmem_addr]);
                    mem_model[pmem_addr] = pmem_wdata;
                    mem_writes++;
                end
                rdata = mem_model[pmem_addr];
                @(posedge clk);
                pmem_resp <= 1'b1;
                pmem_rdata <= rdata;
                @(posedge clk);
                pmem_resp <= 1'b0;
            end
        end
    end

    initial
    begin
        access_t acc;
        cnt_t miss_before;
        cnt_t vhit_before;
        int cycles;
        logic seen;
        logic timed_out;

        errors = 0;
        mem_writes = 0;
        timed_out = 1'b0;
        rst <= 1'b1;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        mem_addr <= '0;
        mem_wdata <= '0;
        for (int a = 0; a < mem_words; a++)
        begin
            mem_model[a] = fill_pattern(addr_t'(a));
            shadow[a] = fill_pattern(addr_t'(a));
        end
        build_table();
        repeat (10)
            @(posedge clk);
        rst <= 1'b0;

        foreach (accesses[i])
        begin
            acc = accesses[i];
            miss_before = miss_count;
            vhit_before = victim_hit_count;
            @(posedge clk);
            mem_read <= !acc.wr;
            mem_write <= acc.wr;
            mem_addr <= acc.addr;
            mem_wdata <= acc.data;
            wait_resp(cycles, seen);
            if (!seen)
            begin
                $display("timeout: no response to access %0d at address %h", i, acc.addr);
                errors++;
                timed_out = 1'b1;
                break;
            end
            if (acc.wr)
                shadow[acc.addr] = acc.data;
            else
                check_value("mem_rdata", mem_rdata, shadow[acc.addr]);
            // a hit answers in CHECK and a victim hit after one SWAP
            if (acc.cls != full_miss)
                check_value("resp latency", 32'(cycles), acc.cls == main_hit ? 32'd2 : 32'd4);
            check_value("miss_count", 32'(miss_count),
                        32'(miss_before) + 32'(acc.cls == full_miss));
            check_value("victim_hit_count", 32'(victim_hit_count),
                        32'(vhit_before) + 32'(acc.cls == victim_hit));
            @(posedge clk);
            mem_read <= 1'b0;
            mem_write <= 1'b0;
        end

        if (!timed_out)
        begin
            check_value("writeback_count", 32'(writeback_count), 32'(mem_writes));
            check_value("mem_writes", 32'(mem_writes), 32'(expected_writebacks));
            foreach (wb_lines[i])
                check_value("mem_model", mem_model[wb_lines[i]], shadow[wb_lines[i]]);
        end

        $display("%0d accesses, %0d errors", accesses.size(), errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule : dcache_tb

/* sources.f */
+incdir+common
common/dcache_pkg.sv
common/dcache_ctrl_if.sv
dcache/dcache_control.sv
dcache/dcache_datapath.sv
dcache/victim_cache.sv
logic/dcache_top.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sources.f --top-module dcache_tb \
    -Mdir "$build_dir" -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/dcache_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log_file"; then
    exit 0
fi
exit 1
